// File: hw/data_ram.sv
module data_ram (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       wen,
    input  logic                       req,
    input  logic [mem_pkg::RAM_AW-1:0] waddr,
    input  logic [mem_pkg::RAM_AW-1:0] raddr,
    input  mem_pkg::store_lane_t       store_lane,
    output logic [mem_pkg::XLEN-1:0]   rdata_raw
);

    import mem_pkg::*;

    logic [XLEN-1:0] mem [RAM_WORDS];

    ////////////////////////////////////////
    // Write port
    ////////////////////////////////////////

    // Byte lanes are written independently under the strobe.
    always_ff @(posedge clk) begin
        if (!reset && wen) begin
            for (int i = 0; i < STRB_W; i++) begin
                if (store_lane.strb[i]) begin
                    mem[waddr][i*BYTE_W +: BYTE_W] <= store_lane.data[i*BYTE_W +: BYTE_W];
                end
            end
        end
    end

    ////////////////////////////////////////
    // Read port
    ////////////////////////////////////////

    // Combinational read, zero when idle.
    assign rdata_raw = req ? mem[raddr] : '0;

endmodule

// File: hw/load_lane_extend.sv
module load_lane_extend (
    input  logic [mem_pkg::XLEN-1:0] rdata_raw,
    input  mem_pkg::load_ctrl_t      load_ctrl,
    output logic [mem_pkg::XLEN-1:0] rdata
);

    import mem_pkg::*;

    logic [XLEN-1:0] shifted;

    // Bring the addressed lane down to bit 0.
    assign shifted = rdata_raw >> {load_ctrl.offset, 3'b000};

    ////////////////////////////////////////
    // Extension
    ////////////////////////////////////////

    always_comb begin
        case (load_ctrl.access)
            ACC_LB: begin
                rdata = {{(XLEN - 8){shifted[7]}}, shifted[7:0]};
            end
            ACC_LH: begin
                rdata = {{(XLEN - 16){shifted[15]}}, shifted[15:0]};
            end
            ACC_LBU: begin
                rdata = {{(XLEN - 8){1'b0}}, shifted[7:0]};
            end
            ACC_LHU: begin
                rdata = {{(XLEN - 16){1'b0}}, shifted[15:0]};
            end
            ACC_LW: begin
                rdata = shifted;
            end
            // Stores and unknown kinds see the shifted word as is.
            default: begin
                rdata = shifted;
            end
        endcase
    end

endmodule

// File: hw/mem_access_decode.sv
module mem_access_decode (
    input  logic [31:0]               inst,
    input  logic [mem_pkg::XLEN-1:0]  raddr,
    output mem_pkg::access_e          access,
    output mem_pkg::load_ctrl_t       load_ctrl
);

    import mem_pkg::*;

    opcode_e    opcode;
    logic [2:0] funct3;

    assign opcode = opcode_e'(inst[6:0]);
    assign funct3 = inst[14:12];

    ////////////////////////////////////////
    // Access kind
    ////////////////////////////////////////

    always_comb begin
        access = ACC_NONE;
        case (opcode)
            OP_LOAD: begin
                case (funct3)
                    F3_B: begin
                        access = ACC_LB;
                    end
                    F3_H: begin
                        access = ACC_LH;
                    end
                    F3_W: begin
                        access = ACC_LW;
                    end
                    F3_BU: begin
                        access = ACC_LBU;
                    end
                    F3_HU: begin
                        access = ACC_LHU;
                    end
                    default: begin
                        access = ACC_NONE;
                    end
                endcase
            end
            OP_STORE: begin
                case (funct3)
                    F3_B: begin
                        access = ACC_SB;
                    end
                    F3_H: begin
                        access = ACC_SH;
                    end
                    F3_W: begin
                        access = ACC_SW;
                    end
                    default: begin
                        access = ACC_NONE;
                    end
                endcase
            end
            default: begin
                access = ACC_NONE;
            end
        endcase
    end

    // Only the byte offset of the read address matters to the load path.
    assign load_ctrl.access = access;
    assign load_ctrl.offset = raddr[OFFSET_W-1:0];

endmodule

// File: hw/mem_pkg.sv
package mem_pkg;

    ////////////////////////////////////////
    // Sizes
    ////////////////////////////////////////

    localparam int XLEN      = 32;
    localparam int BYTE_W    = 8;
    localparam int STRB_W    = XLEN / BYTE_W;
    localparam int OFFSET_W  = $clog2(STRB_W);
    localparam int RAM_WORDS = 256;
    localparam int RAM_AW    = $clog2(RAM_WORDS);

    // Load and store width codes in funct3.
    localparam logic [2:0] F3_B  = 3'b000;
    localparam logic [2:0] F3_H  = 3'b001;
    localparam logic [2:0] F3_W  = 3'b010;
    localparam logic [2:0] F3_BU = 3'b100;
    localparam logic [2:0] F3_HU = 3'b101;

    ////////////////////////////////////////
    // Encodings
    ////////////////////////////////////////

    // Major opcodes seen by the memory stage.
    typedef enum logic [6:0] {
        OP_LOAD  = 7'b0000011,
        OP_STORE = 7'b0100011
    } opcode_e;

    typedef enum logic [3:0] {
        ACC_NONE = 4'd0,
        ACC_LB   = 4'd1,
        ACC_LH   = 4'd2,
        ACC_LW   = 4'd3,
        ACC_LBU  = 4'd4,
        ACC_LHU  = 4'd5,
        ACC_SB   = 4'd6,
        ACC_SH   = 4'd7,
        ACC_SW   = 4'd8
    } access_e;

    ////////////////////////////////////////
    // Lane bundles
    ////////////////////////////////////////

    // Write data already moved to its byte lanes.
    typedef struct packed {
        logic [XLEN-1:0]   data;
        logic [STRB_W-1:0] strb;
    } store_lane_t;

    // What the load path needs to pick and extend a lane.
    typedef struct packed {
        access_e             access;
        logic [OFFSET_W-1:0] offset;
    } load_ctrl_t;

endpackage

// File: hw/mem_subsys.sv
module mem_subsys (
    input  logic                     clk,
    input  logic                     reset,
    input  logic [31:0]              inst,
    input  logic [mem_pkg::XLEN-1:0] raddr,
    input  logic [mem_pkg::XLEN-1:0] waddr,
    input  logic [mem_pkg::XLEN-1:0] wdata,
    input  logic                     wen,
    input  logic                     req,
    output logic [mem_pkg::XLEN-1:0] rdata
);

    import mem_pkg::*;

    access_e         access;
    load_ctrl_t      load_ctrl;
    store_lane_t     store_lane;
    logic [XLEN-1:0] rdata_raw;

    ////////////////////////////////////////
    // Decode and store path
    ////////////////////////////////////////

    mem_access_decode mem_access_decode_i (
        .inst      (inst),
        .raddr     (raddr),
        .access    (access),
        .load_ctrl (load_ctrl)
    );

    store_lane_align store_lane_align_i (
        .waddr      (waddr),
        .wdata      (wdata),
        .access     (access),
        .store_lane (store_lane)
    );

    ////////////////////////////////////////
    // Memory and load path
    ////////////////////////////////////////

    // Word index sits just above the byte offset.
    data_ram data_ram_i (
        .clk        (clk),
        .reset      (reset),
        .wen        (wen),
        .req        (req),
        .waddr      (waddr[RAM_AW+OFFSET_W-1:OFFSET_W]),
        .raddr      (raddr[RAM_AW+OFFSET_W-1:OFFSET_W]),
        .store_lane (store_lane),
        .rdata_raw  (rdata_raw)
    );

    load_lane_extend load_lane_extend_i (
        .rdata_raw (rdata_raw),
        .load_ctrl (load_ctrl),
        .rdata     (rdata)
    );

endmodule

// File: hw/store_lane_align.sv
module store_lane_align (
    input  logic [mem_pkg::XLEN-1:0] waddr,
    input  logic [mem_pkg::XLEN-1:0] wdata,
    input  mem_pkg::access_e         access,
    output mem_pkg::store_lane_t     store_lane
);

    import mem_pkg::*;

    logic [OFFSET_W-1:0] offset;
    logic [STRB_W-1:0]   strb_base;

    assign offset = waddr[OFFSET_W-1:0];

    ////////////////////////////////////////
    // Strobe
    ////////////////////////////////////////

    // Unshifted strobe for the access width.
    always_comb begin
        case (access)
            ACC_SB: begin
                strb_base = 4'b0001;
            end
            ACC_SH: begin
                strb_base = 4'b0011;
            end
            ACC_SW: begin
                strb_base = 4'b1111;
            end
            default: begin
                strb_base = '0;
            end
        endcase
    end

    // Lanes pushed past the top of the word fall off.
    assign store_lane.strb = strb_base << offset;

    ////////////////////////////////////////
    // Data
    ////////////////////////////////////////

    assign store_lane.data = wdata << {offset, 3'b000};

endmodule

// File: run.sh
#!/bin/sh
# Build and run the memory subsystem testbench with Verilator.

cd "$(dirname "$0")"
status=$?
if [ $status -ne 0 ]; then
    echo "cannot enter the project directory"
    exit $status
fi

verilator --binary --timing --assert -f vlog.f --top-module mem_subsys_tb \
    -Mdir obj_dir -o mem_subsys_sim
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit $status
fi

./obj_dir/mem_subsys_sim
status=$?
if [ $status -ne 0 ]; then
    echo "simulation failed with status $status"
    exit $status
fi

exit 0

// File: testbench/mem_patterns.hex
// Columns: inst_raddr_waddr_wdata_ctrl_rdata, all hex, one vector per line.
// ctrl bits: 2 reset, 1 wen, 0 req. rdata is expected just before the next rising edge.
// Word round trip, including address bits above the word index.
00002023_00000000_00000010_deadbeef_2_00000000
00002003_00000010_00000000_00000000_1_deadbeef
00002023_00000000_000003fc_12345678_2_00000000
00002003_000003fc_00000000_00000000_1_12345678
00002023_00000000_00000400_a5a5a5a5_2_00000000
00002003_00000000_00000000_00000000_1_a5a5a5a5
00002003_00000400_00000000_00000000_1_a5a5a5a5
00002003_00000010_00000000_00000000_1_deadbeef
// Byte stores at each offset.
00002023_00000000_00000020_11223344_2_00000000
00000023_00000000_00000020_000000aa_2_00000000
00002003_00000020_00000000_00000000_1_112233aa
00000023_00000000_00000021_ffffffbb_2_00000000
00002003_00000020_00000000_00000000_1_1122bbaa
00000023_00000000_00000022_000000cc_2_00000000
00002003_00000020_00000000_00000000_1_11ccbbaa
00000023_00000000_00000023_000000dd_2_00000000
00002003_00000020_00000000_00000000_1_ddccbbaa
// Halfword stores, upper lanes drop off at offsets 1 and 3.
00002023_00000000_00000030_55667788_2_00000000
00001023_00000000_00000030_0000f00d_2_00000000
00002003_00000030_00000000_00000000_1_5566f00d
00001023_00000000_00000032_0000beef_2_00000000
00002003_00000030_00000000_00000000_1_beeff00d
00001023_00000000_00000031_00001234_2_00000000
00002003_00000030_00000000_00000000_1_be12340d
00001023_00000000_00000033_00009876_2_00000000
00002003_00000030_00000000_00000000_1_7612340d
00002023_00000000_00000040_cafef00d_2_00000000
00002023_00000000_00000041_01020304_2_00000000
00002003_00000040_00000000_00000000_1_0203040d
// Signed loads.
00002023_00000000_00000050_8c7f12f0_2_00000000
00000003_00000050_00000000_00000000_1_fffffff0
00000003_00000051_00000000_00000000_1_00000012
00000003_00000052_00000000_00000000_1_0000007f
00000003_00000053_00000000_00000000_1_ffffff8c
00001003_00000050_00000000_00000000_1_000012f0
00001003_00000051_00000000_00000000_1_00007f12
00001003_00000052_00000000_00000000_1_ffff8c7f
00001003_00000053_00000000_00000000_1_0000008c
00002023_00000000_00000060_7fff8000_2_00000000
00001003_00000060_00000000_00000000_1_ffff8000
00001003_00000062_00000000_00000000_1_00007fff
00000003_00000061_00000000_00000000_1_ffffff80
00000003_00000062_00000000_00000000_1_ffffffff
00000003_00000063_00000000_00000000_1_0000007f
// Unsigned loads, and a word load at offset 2.
00004003_00000050_00000000_00000000_1_000000f0
00004003_00000051_00000000_00000000_1_00000012
00004003_00000052_00000000_00000000_1_0000007f
00004003_00000053_00000000_00000000_1_0000008c
00005003_00000050_00000000_00000000_1_000012f0
00005003_00000051_00000000_00000000_1_00007f12
00005003_00000052_00000000_00000000_1_00008c7f
00005003_00000053_00000000_00000000_1_0000008c
00004003_00000061_00000000_00000000_1_00000080
00005003_00000060_00000000_00000000_1_00008000
00002003_00000052_00000000_00000000_1_00008c7f
// Idle read port and writes that must not land.
00002003_00000010_00000000_00000000_0_00000000
00000013_00000010_00000000_00000000_0_00000000
00000013_00000000_00000010_0badf00d_2_00000000
00002003_00000010_00000000_00000000_1_deadbeef
00002003_00000010_00000010_99999999_3_deadbeef
00002003_00000010_00000000_00000000_1_deadbeef
00003023_00000000_00000010_77777777_2_00000000
00002003_00000010_00000000_00000000_1_deadbeef
00003003_00000012_00000000_00000000_1_0000dead
// Writes under reset are blocked, reads still work.
00002023_00000000_00000020_00000000_6_00000000
00000023_00000000_00000023_00000000_6_00000000
00002003_000003fc_00000000_00000000_5_12345678
00002003_00000020_00000000_00000000_1_ddccbbaa
00002003_00000010_00000000_00000000_1_deadbeef

// File: testbench/mem_subsys_sva.sv
module mem_subsys_sva (
    input logic                     clk,
    input logic [31:0]              inst,
    input logic [mem_pkg::XLEN-1:0] waddr,
    input logic                     req,
    input logic [mem_pkg::XLEN-1:0] rdata,
    input mem_pkg::store_lane_t     store_lane
);

    timeunit 1ns;
    timeprecision 100ps;

    import mem_pkg::*;

    logic is_load;
    logic is_store;
    logic is_word_store;

    assign is_load       = (inst[6:0] == OP_LOAD);
    assign is_store      = (inst[6:0] == OP_STORE);
    assign is_word_store = is_store && (inst[14:12] == F3_W) && (waddr[OFFSET_W-1:0] == '0);

    ////////////////////////////////////////
    // Read port
    ////////////////////////////////////////

    idle_rdata_zero: assert property (@(posedge clk) (!req && !is_load) |-> (rdata == '0))
        else $error("rdata not zero while the read port is idle");

    ////////////////////////////////////////
    // Write strobes
    ////////////////////////////////////////

    strobe_needs_store: assert property (@(posedge clk) (store_lane.strb != '0) |-> is_store)
        else $error("byte strobe set without a store opcode");

    // An aligned word store covers every lane.
    word_store_full_strobe: assert property (@(posedge clk) is_word_store |-> (&store_lane.strb))
        else $error("aligned word store without a full byte strobe");

endmodule

bind mem_subsys mem_subsys_sva mem_subsys_sva_i (
    .clk        (clk),
    .inst       (inst),
    .waddr      (waddr),
    .req        (req),
    .rdata      (rdata),
    .store_lane (store_lane)
);

// File: testbench/mem_subsys_tb.sv
module mem_subsys_tb;

    timeunit 1ns;
    timeprecision 100ps;

    import mem_pkg::*;

    localparam int CLK_PERIOD       = 40;
    localparam int RESET_CYCLES     = 3;
    localparam int CHECK_LEAD       = 2;
    localparam int MAX_VECTORS      = 128;
    localparam int VECTOR_W         = 164;
    localparam int RESET_TIMEOUT_NS = 10 * CLK_PERIOD;
    localparam int RUN_TIMEOUT_NS   = (MAX_VECTORS + 8) * CLK_PERIOD;

    // One line of the patterns file.
    typedef struct packed {
        logic [31:0]     inst;
        logic [XLEN-1:0] raddr;
        logic [XLEN-1:0] waddr;
        logic [XLEN-1:0] wdata;
        logic            end_mark;
        logic            reset;
        logic            wen;
        logic            req;
        logic [XLEN-1:0] rdata;
    } vector_t;

    logic            clk;
    logic            reset;
    logic [31:0]     inst;
    logic [XLEN-1:0] raddr;
    logic [XLEN-1:0] waddr;
    logic [XLEN-1:0] wdata;
    logic            wen;
    logic            req;
    logic [XLEN-1:0] rdata;

    logic [VECTOR_W-1:0] patterns [MAX_VECTORS];
    int                  applied;

    mem_subsys mem_subsys_i (
        .clk   (clk),
        .reset (reset),
        .inst  (inst),
        .raddr (raddr),
        .waddr (waddr),
        .wdata (wdata),
        .wen   (wen),
        .req   (req),
        .rdata (rdata)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    ////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TESTS FAILED");
        $fatal(1, "run aborted");
    endtask

    // Unused entries keep end_mark set, so replay stops after the last line.
    task automatic load_patterns();
        for (int i = 0; i < MAX_VECTORS; i++) begin
            patterns[i] = {32'(i), 32'(i), 32'(i), 32'(i), 4'hf, 32'(i)};
        end
        $readmemh("testbench/mem_patterns.hex", patterns);
    endtask

    task automatic drive_idle();
        inst  = '0;
        raddr = '0;
        waddr = '0;
        wdata = '0;
        wen   = 1'b0;
        req   = 1'b0;
    endtask

    task automatic apply_vector(input vector_t vec);
        inst  = vec.inst;
        raddr = vec.raddr;
        waddr = vec.waddr;
        wdata = vec.wdata;
        reset = vec.reset;
        wen   = vec.wen;
        req   = vec.req;
    endtask

    task automatic hold_reset();
        int  edges;
        time start;
        edges = 0;
        start = $time;
        reset = 1'b1;
        while (edges < RESET_CYCLES) begin
            if ($time - start > 64'(RESET_TIMEOUT_NS)) begin
                abort_run("reset sequence did not complete within the timeout");
            end
            @(posedge clk);
            edges++;
        end
        @(negedge clk);
        reset = 1'b0;
    endtask

    task automatic check_rdata(input int idx, input logic [XLEN-1:0] expected);
        assert (rdata === expected) else begin
            abort_run($sformatf("FAIL: rdata = 0x%08h, expected 0x%08h (vector %0d)",
                                rdata, expected, idx));
        end
    endtask

    ////////////////////////////////////////
    // Replay
    ////////////////////////////////////////

    // Inputs change on the falling edge, rdata is sampled just before the rising one.
    task automatic run_patterns();
        vector_t vec;
        time     start;
        start   = $time;
        applied = 0;
        vec     = vector_t'(patterns[0]);
        while (!vec.end_mark) begin
            if ($time - start > 64'(RUN_TIMEOUT_NS)) begin
                abort_run("pattern replay did not finish within the timeout");
            end
            @(negedge clk);
            apply_vector(vec);
            #(CLK_PERIOD / 2 - CHECK_LEAD);
            check_rdata(applied, vec.rdata);
            applied++;
            if (applied < MAX_VECTORS) begin
                vec = vector_t'(patterns[applied]);
            end else begin
                vec.end_mark = 1'b1;
            end
        end
    endtask

    initial begin
        reset = 1'b1;
        drive_idle();
        load_patterns();
        hold_reset();
        run_patterns();
        @(negedge clk);
        drive_idle();
        if (applied > 0) begin
            $display("%0d vectors checked", applied);
            $display("TESTS PASSED");
            $finish;
        end else begin
            abort_run("patterns file holds no vectors");
        end
    end

endmodule

// File: vlog.f
hw/mem_pkg.sv
hw/mem_access_decode.sv
hw/store_lane_align.sv
hw/load_lane_extend.sv
hw/data_ram.sv
hw/mem_subsys.sv
testbench/mem_subsys_sva.sv
testbench/mem_subsys_tb.sv
